// ==== list.f ====
logic/rv32i_pkg.sv
logic/rv32i_fetch.sv
logic/rv32i_decoder.sv
logic/rv32i_basereg.sv
logic/rv32i_forwarding.sv
logic/rv32i_execute.sv
logic/rv32i_memoryaccess.sv
logic/rv32i_core.sv
testbench/rv32i_assertions.sv
testbench/rv32i_checker.sv
testbench/rv32i_tb.sv

// ==== logic/rv32i_basereg.sv ====
// integer register file, x1..x31 with x0 hardwired to zero and registered read ports
module rv32i_basereg (
    input  logic                  i_clk,
    input  logic                  i_stall,
    input  rv32i_pkg::reg_addr_t  i_rs1_addr,
    input  rv32i_pkg::reg_addr_t  i_rs2_addr,
    input  rv32i_pkg::rd_wr_t     i_rd_wr,    // writeback port
    output rv32i_pkg::word_t      o_rs1,
    output rv32i_pkg::word_t      o_rs2
);
    import rv32i_pkg::*;

    word_t     regs [1:31]; // x0 has no storage
    reg_addr_t rs1_addr_q;  // index behind o_rs1
    reg_addr_t rs2_addr_q;
    reg_addr_t rs1_sel;
    reg_addr_t rs2_sel;

    // during a stall the held indices are re-read so writes landing meanwhile are seen
    assign rs1_sel = i_stall ? rs1_addr_q : i_rs1_addr;
    assign rs2_sel = i_stall ? rs2_addr_q : i_rs2_addr;

    function automatic word_t read_port(input reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (i_rd_wr.wr && (i_rd_wr.addr == addr)) begin
            value = i_rd_wr.data; // write-first bypass
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_rd_wr.wr && (i_rd_wr.addr != '0)) begin
            regs[i_rd_wr.addr] <= i_rd_wr.data;
        end
        rs1_addr_q <= rs1_sel;
        rs2_addr_q <= rs2_sel;
        o_rs1      <= read_port(rs1_sel);
        o_rs2      <= read_port(rs2_sel);
    end

endmodule

// ==== logic/rv32i_core.sv ====
// top level of the five-stage RV32I pipeline, wires fetch through writeback
module rv32i_core (
    input  logic              i_clk,
    input  logic              i_arst_n,
    // instruction rom, combinational
    input  rv32i_pkg::word_t  i_inst,
    output rv32i_pkg::word_t  o_iaddr,
    // data ram, synchronous read
    input  rv32i_pkg::word_t  i_din,
    output rv32i_pkg::word_t  o_daddr,
    output rv32i_pkg::word_t  o_dout,
    output logic              o_wr_en
);
    import rv32i_pkg::*;

    if_id_t    if_id;    // fetch -> decode
    id_ex_t    id_ex;    // decode -> execute
    ex_mem_t   ex_mem;   // execute -> memory access
    rd_wr_t    rd_wr;    // writeback -> regfile
    reg_addr_t rs1_addr; // regfile read indices
    reg_addr_t rs2_addr;
    word_t     rs1_raw;  // regfile outputs
    word_t     rs2_raw;
    word_t     rs1_fwd;  // forwarded operands
    word_t     rs2_fwd;
    logic      stall;    // load-use hold

    rv32i_fetch u_fetch (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_inst(i_inst), .i_stall(stall),
        .o_iaddr(o_iaddr), .o_if_id(if_id)
    );

    rv32i_decoder u_decoder (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_if_id(if_id), .i_stall(stall),
        .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr),
        .o_id_ex(id_ex)
    );

    rv32i_basereg u_basereg (
        .i_clk(i_clk), .i_stall(stall),
        .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
        .i_rd_wr(rd_wr),
        .o_rs1(rs1_raw), .o_rs2(rs2_raw)
    );

    rv32i_forwarding u_forwarding (
        .i_rs1_raw(rs1_raw), .i_rs2_raw(rs2_raw),
        .i_id_ex(id_ex), .i_ex_mem(ex_mem), .i_rd_wr(rd_wr),
        .o_rs1(rs1_fwd), .o_rs2(rs2_fwd), .o_stall(stall)
    );

    rv32i_execute u_execute (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_id_ex(id_ex), .i_rs1(rs1_fwd), .i_rs2(rs2_fwd),
        .i_stall(stall), .o_ex_mem(ex_mem)
    );

    rv32i_memoryaccess u_memoryaccess (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_ex_mem(ex_mem), .i_din(i_din),
        .o_daddr(o_daddr), .o_dout(o_dout), .o_wr_en(o_wr_en),
        .o_rd_wr(rd_wr)
    );

endmodule

// ==== logic/rv32i_decoder.sv ====
// decode stage, turns an RV32I word into ALU op, flags, register indices and immediate
module rv32i_decoder (
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  rv32i_pkg::if_id_t     i_if_id,
    input  logic                  i_stall,
    output rv32i_pkg::reg_addr_t  o_rs1_addr, // to regfile, read at the id_ex edge
    output rv32i_pkg::reg_addr_t  o_rs2_addr,
    output rv32i_pkg::id_ex_t     o_id_ex
);
    import rv32i_pkg::*;

    id_ex_t dec;      // decoded entry, combinational
    id_ex_t id_ex_q;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;

    assign opcode = i_if_id.inst[6:0];
    assign funct3 = i_if_id.inst[14:12];
    assign funct7 = i_if_id.inst[31:25];
    assign imm_i  = {{20{i_if_id.inst[31]}}, i_if_id.inst[31:20]};
    assign imm_s  = {{20{i_if_id.inst[31]}}, i_if_id.inst[31:25], i_if_id.inst[11:7]};

    always_comb begin
        dec          = '0;
        dec.valid    = 1'b0;
        dec.rs1      = i_if_id.inst[19:15];
        dec.rs2      = i_if_id.inst[24:20];
        dec.rd       = i_if_id.inst[11:7];
        dec.alu_op   = ALU_ADD;
        case (opcode)
            OPC_OP_IMM: begin
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
                dec.rs2     = '0; // no second source
                dec.valid   = 1'b1;
                case (funct3)
                    F3_ADD_SUB: dec.alu_op = ALU_ADD;
                    F3_SLT:     dec.alu_op = ALU_SLT;
                    F3_SLTU:    dec.alu_op = ALU_SLTU;
                    F3_XOR:     dec.alu_op = ALU_XOR;
                    F3_OR:      dec.alu_op = ALU_OR;
                    F3_AND:     dec.alu_op = ALU_AND;
                    F3_SLL: begin
                        dec.alu_op = ALU_SLL;
                        dec.valid  = (funct7 == F7_BASE); // shamt[5] must be 0
                    end
                    default: begin // srli / srai
                        dec.alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                        dec.valid  = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    end
                endcase
            end
            OPC_OP: begin
                dec.valid = (funct7 == F7_BASE) ||
                            ((funct7 == F7_ALT) &&
                             ((funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA)));
                case (funct3)
                    F3_ADD_SUB: dec.alu_op = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     dec.alu_op = ALU_SLL;
                    F3_SLT:     dec.alu_op = ALU_SLT;
                    F3_SLTU:    dec.alu_op = ALU_SLTU;
                    F3_XOR:     dec.alu_op = ALU_XOR;
                    F3_SRL_SRA: dec.alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:      dec.alu_op = ALU_OR;
                    default:    dec.alu_op = ALU_AND;
                endcase
            end
            OPC_LOAD: begin
                dec.valid   = (funct3 == F3_WORD); // lw only
                dec.is_load = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
                dec.rs2     = '0;
            end
            OPC_STORE: begin
                dec.valid    = (funct3 == F3_WORD); // sw only
                dec.is_store = 1'b1;
                dec.use_imm  = 1'b1;
                dec.imm      = imm_s;
                dec.rd       = '0; // stores write no register
            end
            default: dec.valid = 1'b0;
        endcase
        if (!(dec.valid && i_if_id.valid)) begin
            dec = '0; // unknown word or empty slot becomes a bubble
        end
    end

    assign o_rs1_addr = dec.rs1;
    assign o_rs2_addr = dec.rs2;
    assign o_id_ex    = id_ex_q;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            id_ex_q <= '0;
        end else if (!i_stall) begin
            id_ex_q <= dec; // held while execute waits on a load
        end
    end

endmodule

// ==== logic/rv32i_execute.sv ====
// execute stage, ALU and the execute to memory register
module rv32i_execute (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  rv32i_pkg::id_ex_t   i_id_ex,
    input  rv32i_pkg::word_t    i_rs1,    // forwarded operands
    input  rv32i_pkg::word_t    i_rs2,
    input  logic                i_stall,
    output rv32i_pkg::ex_mem_t  o_ex_mem
);
    import rv32i_pkg::*;

    word_t   op_a;
    word_t   op_b;
    word_t   alu_y;
    ex_mem_t ex_next;
    ex_mem_t ex_mem_q;

    assign op_a = i_rs1;
    assign op_b = i_id_ex.use_imm ? i_id_ex.imm : i_rs2; // lw/sw take base + offset

    always_comb begin
        case (i_id_ex.alu_op)
            ALU_ADD:  alu_y = op_a + op_b;
            ALU_SUB:  alu_y = op_a - op_b;
            ALU_SLL:  alu_y = op_a << op_b[4:0];
            ALU_SLT:  alu_y = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_y = {31'd0, op_a < op_b};
            ALU_XOR:  alu_y = op_a ^ op_b;
            ALU_SRL:  alu_y = op_a >> op_b[4:0];
            ALU_SRA:  alu_y = $signed(op_a) >>> op_b[4:0]; // sign fill
            ALU_OR:   alu_y = op_a | op_b;
            ALU_AND:  alu_y = op_a & op_b;
            default:  alu_y = '0;
        endcase
    end

    always_comb begin
        ex_next.valid      = i_id_ex.valid;
        ex_next.is_load    = i_id_ex.valid && i_id_ex.is_load;
        ex_next.is_store   = i_id_ex.valid && i_id_ex.is_store;
        ex_next.rd         = i_id_ex.rd;
        ex_next.wr_rd      = i_id_ex.valid && (i_id_ex.rd != '0); // decoder zeroes rd of sw
        ex_next.result     = alu_y;
        ex_next.store_data = i_rs2;
    end

    assign o_ex_mem = ex_mem_q;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ex_mem_q <= '0;
        end else if (i_stall) begin
            ex_mem_q <= '0; // bubble while the load-use slot opens
        end else begin
            ex_mem_q <= ex_next;
        end
    end

endmodule

// ==== logic/rv32i_fetch.sv ====
// fetch stage, program counter plus the fetch to decode register
module rv32i_fetch (
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  rv32i_pkg::word_t   i_inst,   // word at o_iaddr, same cycle
    input  logic               i_stall,  // load-use hold
    output rv32i_pkg::word_t   o_iaddr,
    output rv32i_pkg::if_id_t  o_if_id
);
    import rv32i_pkg::*;

    word_t  pc_q;     // address being fetched now
    if_id_t if_id_q;  // word handed to decode

    assign o_iaddr = pc_q;
    assign o_if_id = if_id_q;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q    <= PC_RESET;
            if_id_q <= '0; // decode sees a bubble first
        end else if (!i_stall) begin
            pc_q          <= pc_q + 32'd4; // no branches, always sequential
            if_id_q.valid <= 1'b1;
            if_id_q.pc    <= pc_q;
            if_id_q.inst  <= i_inst;
        end
        // stall: pc and fetched word both held
    end

endmodule

// ==== logic/rv32i_forwarding.sv ====
// operand forwarding into execute and load-use stall detection
module rv32i_forwarding (
    input  rv32i_pkg::word_t   i_rs1_raw,  // regfile values
    input  rv32i_pkg::word_t   i_rs2_raw,
    input  rv32i_pkg::id_ex_t  i_id_ex,    // entry in execute
    input  rv32i_pkg::ex_mem_t i_ex_mem,   // entry in memory access
    input  rv32i_pkg::rd_wr_t  i_rd_wr,    // entry in writeback
    output rv32i_pkg::word_t   o_rs1,
    output rv32i_pkg::word_t   o_rs2,
    output logic               o_stall
);
    import rv32i_pkg::*;

    logic mem_hit_rs1; // load in memory stage feeds rs1
    logic mem_hit_rs2;

    // youngest producer wins, x0 never matches
    function automatic word_t select(input reg_addr_t src, input word_t raw);
        word_t value;
        if (src == '0) begin
            value = raw;
        end else if (i_ex_mem.valid && i_ex_mem.wr_rd && (i_ex_mem.rd == src)) begin
            value = i_ex_mem.result; // one ahead
        end else if (i_rd_wr.wr && (i_rd_wr.addr == src)) begin
            value = i_rd_wr.data; // two ahead, load data included
        end else begin
            value = raw;
        end
        return value;
    endfunction

    assign o_rs1 = select(i_id_ex.rs1, i_rs1_raw);
    assign o_rs2 = select(i_id_ex.rs2, i_rs2_raw);

    assign mem_hit_rs1 = (i_id_ex.rs1 != '0) && (i_id_ex.rs1 == i_ex_mem.rd);
    assign mem_hit_rs2 = (i_id_ex.rs2 != '0) && (i_id_ex.rs2 == i_ex_mem.rd);

    // load data is not on i_din yet, so execute waits one cycle
    assign o_stall = i_id_ex.valid && i_ex_mem.valid && i_ex_mem.is_load &&
                     i_ex_mem.wr_rd && (mem_hit_rs1 || mem_hit_rs2);

endmodule

// ==== logic/rv32i_memoryaccess.sv ====
// memory access stage, data port drive, writeback register and load data select
module rv32i_memoryaccess (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  rv32i_pkg::ex_mem_t  i_ex_mem,
    input  rv32i_pkg::word_t    i_din,    // word at last cycle's o_daddr
    output rv32i_pkg::word_t    o_daddr,
    output rv32i_pkg::word_t    o_dout,
    output logic                o_wr_en,
    output rv32i_pkg::rd_wr_t   o_rd_wr
);
    import rv32i_pkg::*;

    rd_wr_t wb_q;       // rd write waiting for writeback, data is alu result
    logic   wb_load_q;  // take i_din instead of the alu result

    // data port straight from the execute register
    assign o_daddr = i_ex_mem.result;
    assign o_dout  = i_ex_mem.store_data;
    assign o_wr_en = i_ex_mem.valid && i_ex_mem.is_store;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wb_q      <= '0;
            wb_load_q <= 1'b0;
        end else begin
            wb_q.wr   <= i_ex_mem.valid && i_ex_mem.wr_rd;
            wb_q.addr <= i_ex_mem.rd;
            wb_q.data <= i_ex_mem.result;
            wb_load_q <= i_ex_mem.valid && i_ex_mem.is_load;
        end
    end

    // ram returns load data one cycle late, right here
    always_comb begin
        o_rd_wr      = wb_q;
        o_rd_wr.data = wb_load_q ? i_din : wb_q.data;
    end

endmodule

// ==== logic/rv32i_pkg.sv ====
// rv32i pipeline package with widths, instruction encodings and stage payload records
package rv32i_pkg;

    localparam int XLEN       = 32; // data and address width
    localparam int REG_ADDR_W = 5;  // x0..x31

    localparam logic [XLEN-1:0] PC_RESET = 32'h0000_0000; // first fetch address

    // major opcodes kept by this core
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000; // also addi
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010; // lw / sw width

    localparam logic [6:0] F7_BASE = 7'b0000000; // add, srl, shifts by imm
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef struct packed {
        logic  valid; // slot holds a fetched word
        word_t pc;    // address the word came from
        word_t inst;  // raw instruction
    } if_id_t;

    typedef struct packed {
        logic      valid;    // low for bubbles and unknown words
        alu_op_t   alu_op;
        logic      use_imm;  // operand b is imm, not rs2
        logic      is_load;
        logic      is_store;
        reg_addr_t rs1;
        reg_addr_t rs2;      // zero for immediate forms
        reg_addr_t rd;       // zero when nothing is written
        word_t     imm;      // sign extended i or s immediate
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      is_load;
        logic      is_store;
        reg_addr_t rd;
        logic      wr_rd;      // rd gets written at writeback
        word_t     result;     // alu value or data address
        word_t     store_data; // forwarded rs2
    } ex_mem_t;

    typedef struct packed {
        logic      wr;
        reg_addr_t addr;
        word_t     data;
    } rd_wr_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run the rv32i testbench with Verilator, verdict from the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module rv32i_tb -Mdir obj_dir -f list.f
./obj_dir/Vrv32i_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -qx "TESTBENCH PASSED" sim.log; then
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi

// ==== testbench/rv32i_assertions.sv ====
// port assertions for the rv32i core, bound into every core instance
module rv32i_assertions (
    input logic             i_clk,
    input logic             i_arst_n,
    input rv32i_pkg::word_t i_iaddr,
    input rv32i_pkg::word_t i_daddr,
    input logic             i_wr_en
);
    int unsigned wr_en_x_fails = 0;
    int unsigned align_fails   = 0;
    int unsigned iaddr_fails   = 0;
    int unsigned fail_count;      // read by the testbench at the end

    assign fail_count = wr_en_x_fails + align_fails + iaddr_fails;

    wr_en_known: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !$isunknown(i_wr_en))
        else begin
            $error("o_wr_en is unknown");
            wr_en_x_fails++;
        end

    store_aligned: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_wr_en |-> (i_daddr[1:0] == 2'b00))
        else begin
            $error("store address %h is not word aligned", i_daddr);
            align_fails++;
        end

    // no branches, so fetch only moves forward
    iaddr_monotonic: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_iaddr >= $past(i_iaddr))
        else begin
            $error("fetch address went back to %h", i_iaddr);
            iaddr_fails++;
        end

endmodule

bind rv32i_core rv32i_assertions u_assertions (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_iaddr(o_iaddr), .i_daddr(o_daddr), .i_wr_en(o_wr_en)
);

// ==== testbench/rv32i_checker.sv ====
// store checker, runs an in-order ISA model of the program and compares every DUT store
module rv32i_checker #(
    parameter int PROG_LEN  = 431,
    parameter int RAM_WORDS = 64
) (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  rv32i_pkg::word_t  i_prog [PROG_LEN],
    input  rv32i_pkg::word_t  i_ram_init [RAM_WORDS],
    input  rv32i_pkg::word_t  i_iaddr,
    input  rv32i_pkg::word_t  i_daddr,
    input  rv32i_pkg::word_t  i_dout,
    input  logic              i_wr_en,
    output int                o_errors,
    output int                o_pending,  // modelled stores not seen yet
    output logic              o_ready     // model has run
);
    import rv32i_pkg::*;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    store_t exp_q [$];     // expected stores, program order
    int     errors    = 0;
    int     pending   = 0;
    logic   ready     = 1'b0;
    int     store_idx = 0;

    assign o_errors  = errors;
    assign o_pending = pending;
    assign o_ready   = ready;

    // integer alu by funct3, alt picks sub and sra
    function automatic word_t alu(input logic [2:0] f3, input logic alt,
                                  input word_t a, input word_t b);
        logic signed [31:0] sa;
        word_t              res;
        sa = a;
        case (f3)
            3'b000:  res = alt ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  res = (a < b) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b101: begin
                if (alt) res = sa >>> b[4:0]; // sign fill
                else res = a >> b[4:0];
            end
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    task automatic build_expected();
        word_t regs [32];
        word_t mem [RAM_WORDS];
        word_t w, a, b, res, addr;
        logic  wr;
        for (int r = 0; r < 32; r++) regs[r] = '0;
        for (int i = 0; i < RAM_WORDS; i++) mem[i] = i_ram_init[i];
        for (int pc = 0; pc < PROG_LEN; pc++) begin
            w   = i_prog[pc];
            a   = regs[w[19:15]];
            b   = regs[w[24:20]];
            wr  = 1'b0;
            res = '0;
            case (w[6:0])
                OPC_OP_IMM: begin // shifts need a clean upper field
                    wr = (w[14:12] == 3'b001) ? (w[31:25] == 7'h00) :
                         (w[14:12] != 3'b101) || (w[31:25] == 7'h00) || (w[31:25] == 7'h20);
                    res = alu(w[14:12], (w[14:12] == 3'b101) && w[30], a,
                              {{20{w[31]}}, w[31:20]});
                end
                OPC_OP: begin
                    wr = (w[31:25] == 7'h00) ||
                         ((w[31:25] == 7'h20) && (w[14:12] == 3'b000 || w[14:12] == 3'b101));
                    res = alu(w[14:12], w[30], a, b);
                end
                OPC_LOAD: if (w[14:12] == 3'b010) begin // lw only
                    addr = a + {{20{w[31]}}, w[31:20]};
                    res  = mem[addr[7:2]];
                    wr   = 1'b1;
                end
                OPC_STORE: if (w[14:12] == 3'b010) begin // sw only
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    mem[addr[7:2]] = b;
                    exp_q.push_back({addr, b});
                end
                default: ; // anything else does nothing
            endcase
            if (wr && w[11:7] != 5'd0) regs[w[11:7]] = res; // x0 stays zero
        end
    endtask

    always @(posedge i_clk) begin
        store_t want;
        if (i_arst_n && !ready) begin // first edge out of reset
            build_expected();
            pending = exp_q.size();
            ready   = 1'b1;
            if (i_iaddr !== PC_RESET) begin
                $display("Mismatch test=first_fetch expected=%h actual=%h", PC_RESET, i_iaddr);
                errors++;
            end
        end else if (ready && i_wr_en === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("unexpected store of %h to %h after all modelled stores", i_dout, i_daddr);
                errors++;
            end else begin
                want = exp_q.pop_front();
                if (i_daddr !== want.addr) begin
                    $display("Mismatch test=store_%0d_addr expected=%h actual=%h",
                             store_idx, want.addr, i_daddr);
                    errors++;
                end
                if (i_dout !== want.data) begin
                    $display("Mismatch test=store_%0d_data expected=%h actual=%h",
                             store_idx, want.data, i_dout);
                    errors++;
                end
                store_idx++;
            end
            pending = exp_q.size();
        end else if (ready && i_wr_en !== 1'b0) begin
            $display("o_wr_en is unknown after reset");
            errors++;
        end
    end

endmodule

// ==== testbench/rv32i_tb.sv ====
// testbench top for the rv32i pipeline, random program, rom and ram models, watchdog and verdict
module rv32i_tb;
    import rv32i_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 10;
    localparam int RAND_LEN        = 400;           // random body
    localparam int PROG_LEN        = RAND_LEN + 31; // plus the x1..x31 dump
    localparam int RAM_WORDS       = 64;
    localparam int WATCHDOG_CYCLES = 2 * PROG_LEN + 50;
    localparam int DRAIN_CYCLES    = 8;             // catches stray stores after the last one

    logic        clk    = 1'b0;
    logic        arst_n = 1'b0;
    word_t       inst;
    word_t       iaddr;
    word_t       din    = '0;
    word_t       daddr;
    word_t       dout;
    logic        wr_en;
    word_t       prog [PROG_LEN];
    word_t       ram_init [RAM_WORDS];
    word_t       ram [RAM_WORDS];
    int          error_count;
    int          pending_count;
    logic        model_ready;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rv32i_core DUT (
        .i_clk(clk), .i_arst_n(arst_n),
        .i_inst(inst), .o_iaddr(iaddr),
        .i_din(din), .o_daddr(daddr), .o_dout(dout), .o_wr_en(wr_en)
    );

    rv32i_checker #(.PROG_LEN(PROG_LEN), .RAM_WORDS(RAM_WORDS)) u_checker (
        .i_clk(clk), .i_arst_n(arst_n), .i_prog(prog), .i_ram_init(ram_init),
        .i_iaddr(iaddr), .i_daddr(daddr), .i_dout(dout), .i_wr_en(wr_en),
        .o_errors(error_count), .o_pending(pending_count), .o_ready(model_ready)
    );

    // same-cycle rom, addi x0 padding past the program
    always_comb begin
        if (iaddr < PROG_LEN * 4) inst = prog[iaddr[10:2]];
        else inst = 32'h0000_0013;
    end

    // synchronous ram, image reloaded while in reset
    always @(posedge clk) begin
        if (!arst_n) begin
            ram <= ram_init;
        end else if (wr_en) begin
            ram[daddr[7:2]] <= dout;
        end
        din <= ram[daddr[7:2]]; // word at this cycle's address, seen next cycle
    end

    function automatic word_t encode_itype(input logic [11:0] imm, input reg_addr_t rs1,
                                           input logic [2:0] f3, input reg_addr_t rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t encode_rtype(input logic [6:0] f7, input reg_addr_t rs2,
                                           input reg_addr_t rs1, input logic [2:0] f3,
                                           input reg_addr_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic word_t encode_stype(input logic [11:0] imm, input reg_addr_t rs2,
                                           input reg_addr_t rs1, input logic [2:0] f3,
                                           input logic [6:0] opc);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
    endfunction

    // mostly x0..x7 so neighbours often depend on each other
    function automatic reg_addr_t pick_reg();
        if ($urandom_range(3, 0) != 0) return reg_addr_t'($urandom_range(7, 0));
        return reg_addr_t'($urandom_range(31, 0));
    endfunction

    function automatic logic [11:0] word_offset();
        return 12'($urandom_range(63, 0) * 4); // 0..252, aligned
    endfunction

    function automatic word_t unsupported_word();
        word_t w;
        w = $urandom();
        case ($urandom_range(3, 0))
            0: w[6:0] = 7'b0110111;                                           // lui
            1: w[6:0] = 7'b1100011;                                           // branch
            2: w = encode_rtype(7'b0000001, pick_reg(), pick_reg(), 3'b000, pick_reg(), OPC_OP);
            default: w = encode_itype(word_offset(), 5'd0, 3'b000, pick_reg(), OPC_LOAD); // lb
        endcase
        return w;
    endfunction

    function automatic word_t random_inst();
        int unsigned kind;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  f7;
        kind = $urandom_range(99, 0);
        f3   = 3'($urandom_range(7, 0));
        imm  = 12'($urandom_range(4095, 0));
        if (kind < 35) begin
            if (f3 == F3_SLL) imm = {F7_BASE, imm[4:0]};
            else if (f3 == F3_SRL_SRA) imm = {(imm[11] ? F7_ALT : F7_BASE), imm[4:0]};
            return encode_itype(imm, pick_reg(), f3, pick_reg(), OPC_OP_IMM);
        end
        if (kind < 65) begin
            f7 = (imm[0] && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA)) ? F7_ALT : F7_BASE; // sub, sra
            return encode_rtype(f7, pick_reg(), pick_reg(), f3, pick_reg(), OPC_OP);
        end
        if (kind < 80) return encode_itype(word_offset(), 5'd0, F3_WORD, pick_reg(), OPC_LOAD);
        if (kind < 93) return encode_stype(word_offset(), pick_reg(), 5'd0, F3_WORD, OPC_STORE);
        return unsupported_word();
    endfunction

    task automatic build_program();
        // register file powers up undefined, so x1..x31 get a random value first
        for (int r = 1; r < 32; r++) begin
            prog[r - 1] = encode_itype(12'($urandom_range(4095, 0)), 5'd0, F3_ADD_SUB,
                                       reg_addr_t'(r), OPC_OP_IMM); // addi xr, x0, imm
        end
        for (int i = 31; i < RAND_LEN; i++) prog[i] = random_inst();
        for (int r = 1; r < 32; r++) begin
            prog[RAND_LEN + r - 1] = encode_stype(12'(r * 4), reg_addr_t'(r), 5'd0, F3_WORD,
                                                  OPC_STORE); // sw xr, 4r(x0)
        end
    endtask

    task automatic build_ram_image();
        word_t a;
        for (int i = 0; i < RAM_WORDS; i++) begin
            a           = word_t'(i * 4);
            ram_init[i] = (a * 32'h9E37_79B9) ^ 32'hC3A5_0F1E; // every address bit matters
        end
    endtask

    initial begin : main
        void'($urandom(53589)); // single seed for the whole run
        build_program();
        build_ram_image();
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        wait (model_ready && pending_count == 0);
        repeat (DRAIN_CYCLES) @(posedge clk);
        $display("closing count: %0d errors, %0d stores missing, %0d assertion failures",
                 error_count, pending_count, DUT.u_assertions.fail_count);
        if (error_count == 0 && DUT.u_assertions.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles, the DUT never produced all expected stores",
                 WATCHDOG_CYCLES);
        $display("closing count: %0d errors, %0d stores missing, %0d assertion failures",
                 error_count, pending_count, DUT.u_assertions.fail_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
